/* filelist.f */
source/soc_pkg.sv
source/device_bus_if.sv
source/bus_controller.sv
source/system_ram.sv
source/gpio_port.sv
source/machine_timer.sv
source/soc_top.sv
sim/soc_tb.sv

/* sim/soc_tb.sv */
// Self-checking testbench acting as bus manager for the peripheral subsystem; run as top soc_tb
`timescale 1ns/1ps

module soc_tb;

  localparam int RESPONSE_TIMEOUT = 20;
  localparam int IRQ_TIMEOUT      = 200;
  localparam int RAM_TEST_WORDS   = 16;

  logic                 clock;
  logic                 reset;
  soc_pkg::bus_addr_t   rw_address_i;
  logic                 read_request_i;
  logic                 write_request_i;
  soc_pkg::bus_data_t   write_data_i;
  soc_pkg::bus_strobe_t write_strobe_i;
  soc_pkg::bus_data_t   read_data_o;
  logic                 read_response_o;
  logic                 write_response_o;
  soc_pkg::gpio_t       gpio_input_i;
  soc_pkg::gpio_t       gpio_oe_o;
  soc_pkg::gpio_t       gpio_output_o;
  logic                 timer_irq_o;

  int unsigned          error_count;
  int unsigned          check_count;
  string                test_name;
  logic [31:0]          lfsr_state;

  // Reference image of RAM and GPIO registers
  soc_pkg::bus_data_t   ram_image [soc_pkg::RAM_WORDS];
  soc_pkg::gpio_t       oe_copy;
  soc_pkg::gpio_t       out_copy;
  soc_pkg::gpio_t       in_copy;
  soc_pkg::ram_index_t  ram_words [RAM_TEST_WORDS];

  // Pending read expectations, oldest first
  soc_pkg::bus_data_t   expected_q [$];
  logic                 check_q [$];
  soc_pkg::bus_data_t   cmp_expected;
  logic                 cmp_enabled;

  soc_top u_dut (
    .clock            (clock),
    .reset            (reset),
    .rw_address_i     (rw_address_i),
    .read_request_i   (read_request_i),
    .write_request_i  (write_request_i),
    .write_data_i     (write_data_i),
    .write_strobe_i   (write_strobe_i),
    .read_data_o      (read_data_o),
    .read_response_o  (read_response_o),
    .write_response_o (write_response_o),
    .gpio_input_i     (gpio_input_i),
    .gpio_oe_o        (gpio_oe_o),
    .gpio_output_o    (gpio_output_o),
    .timer_irq_o      (timer_irq_o)
  );

  always #20 clock = ~clock;

  // --------------------------------------------------------------------------
  // Random numbers and reference model
  // --------------------------------------------------------------------------

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return value;
  endfunction

  function automatic soc_pkg::bus_addr_t ram_addr(input soc_pkg::ram_index_t idx);
    return soc_pkg::RAM_BASE + {20'b0, idx, 2'b00};
  endfunction

  function automatic soc_pkg::bus_addr_t timer_reg(input soc_pkg::reg_offset_t ofs);
    return soc_pkg::TIMER_BASE + 32'(ofs);
  endfunction

  function automatic soc_pkg::bus_addr_t gpio_reg(input soc_pkg::reg_offset_t ofs);
    return soc_pkg::GPIO_BASE + 32'(ofs);
  endfunction

  function automatic void model_write(input soc_pkg::bus_addr_t addr,
                                      input soc_pkg::bus_data_t data,
                                      input soc_pkg::bus_strobe_t strobe);
    soc_pkg::bus_addr_t ofs;
    ofs = addr - soc_pkg::GPIO_BASE;
    if ((addr - soc_pkg::RAM_BASE) < soc_pkg::RAM_SIZE) begin
      for (int b = 0; b < 4; b++) begin
        if (strobe[b]) begin
          ram_image[addr[11:2]][8*b +: 8] = data[8*b +: 8];
        end
      end
    end else if (ofs < soc_pkg::GPIO_SIZE) begin
      // GPIO ignores strobes
      case (ofs[4:0])
        soc_pkg::GPIO_OE_OFS:  oe_copy  = data[soc_pkg::GPIO_WIDTH-1:0];
        soc_pkg::GPIO_OUT_OFS: out_copy = data[soc_pkg::GPIO_WIDTH-1:0];
        soc_pkg::GPIO_SET_OFS: out_copy = out_copy | data[soc_pkg::GPIO_WIDTH-1:0];
        soc_pkg::GPIO_CLR_OFS: out_copy = out_copy & ~data[soc_pkg::GPIO_WIDTH-1:0];
        default: ;
      endcase
    end
  endfunction

  // Expected read value for RAM, GPIO and unmapped addresses
  function automatic soc_pkg::bus_data_t expected_read(input soc_pkg::bus_addr_t addr);
    soc_pkg::bus_addr_t ofs;
    ofs = addr - soc_pkg::GPIO_BASE;
    if ((addr - soc_pkg::RAM_BASE) < soc_pkg::RAM_SIZE) begin
      return ram_image[addr[11:2]];
    end
    if (ofs < soc_pkg::GPIO_SIZE) begin
      case (ofs[4:0])
        soc_pkg::GPIO_IN_OFS:  return 32'(in_copy);
        soc_pkg::GPIO_OE_OFS:  return 32'(oe_copy);
        soc_pkg::GPIO_OUT_OFS: return 32'(out_copy);
        default:               return '0;
      endcase
    end
    return '0;
  endfunction

  // --------------------------------------------------------------------------
  // Bus tasks
  // --------------------------------------------------------------------------

  task automatic bus_access(input logic write, input soc_pkg::bus_addr_t addr,
                            input soc_pkg::bus_data_t data,
                            input soc_pkg::bus_strobe_t strobe,
                            output soc_pkg::bus_data_t rdata);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    rdata  = '0;
    @(negedge clock);
    rw_address_i    = addr;
    write_data_i    = data;
    write_strobe_i  = strobe;
    write_request_i = write;
    read_request_i  = !write;
    @(negedge clock);
    write_request_i = 1'b0;
    read_request_i  = 1'b0;
    while (!done && cycles < RESPONSE_TIMEOUT) begin
      @(negedge clock);
      cycles++;
      done = write ? write_response_o : read_response_o;
    end
    check_count++;
    assert (done) else begin
      error_count++;
      $display("ERROR: %s: no %s response from address %h within %0d cycles",
               test_name, write ? "write" : "read", addr, RESPONSE_TIMEOUT);
      expected_q.delete();
      check_q.delete();
    end
    if (done) begin
      rdata = read_data_o;
      check_count++;
      assert (cycles == 2) else begin
        error_count++;
        $display("FAIL %s latency: expected %0d actual %0d", test_name, 2, cycles);
      end
    end
  endtask

  task automatic write_word(input soc_pkg::bus_addr_t addr, input soc_pkg::bus_data_t data,
                            input soc_pkg::bus_strobe_t strobe);
    soc_pkg::bus_data_t ignored_data;
    model_write(addr, data, strobe);
    bus_access(1'b1, addr, data, strobe, ignored_data);
  endtask

  task automatic read_expect(input soc_pkg::bus_addr_t addr, input soc_pkg::bus_data_t exp);
    soc_pkg::bus_data_t ignored_data;
    expected_q.push_back(exp);
    check_q.push_back(1'b1);
    bus_access(1'b0, addr, '0, '0, ignored_data);
  endtask

  task automatic read_check(input soc_pkg::bus_addr_t addr);
    read_expect(addr, expected_read(addr));
  endtask

  // Read without a fixed expectation, for the running timer
  task automatic read_value(input soc_pkg::bus_addr_t addr, output soc_pkg::bus_data_t data);
    expected_q.push_back('0);
    check_q.push_back(1'b0);
    bus_access(1'b0, addr, '0, '0, data);
  endtask

  task automatic check_value(input string what, input soc_pkg::bus_data_t exp,
                             input soc_pkg::bus_data_t act);
    check_count++;
    assert (act === exp) else begin
      error_count++;
      $display("FAIL %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic wait_for_irq(input logic level, input string why);
    int cycles;
    cycles = 0;
    while (timer_irq_o !== level && cycles < IRQ_TIMEOUT) begin
      @(negedge clock);
      cycles++;
    end
    check_count++;
    assert (timer_irq_o === level) else begin
      error_count++;
      $display("ERROR: %s: timer_irq_o did not go to %0d within %0d cycles after %s",
               test_name, level, IRQ_TIMEOUT, why);
    end
  endtask

  // Read data compare, and zero read data outside responses
  always @(negedge clock) begin
    if (!reset && read_response_o) begin
      if (expected_q.size() == 0) begin
        error_count++;
        $display("ERROR: %s: read response with no read outstanding", test_name);
      end else begin
        cmp_expected = expected_q.pop_front();
        cmp_enabled  = check_q.pop_front();
        if (cmp_enabled) begin
          check_count++;
          assert (read_data_o === cmp_expected) else begin
            error_count++;
            $display("FAIL %s read data: expected %h actual %h",
                     test_name, cmp_expected, read_data_o);
          end
        end
      end
    end else if (!reset) begin
      assert (read_data_o === '0) else begin
        error_count++;
        $display("FAIL %s idle read data: expected %h actual %h", test_name, 32'h0, read_data_o);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    soc_pkg::bus_data_t data;
    soc_pkg::bus_data_t prev;
    clock           = 1'b0;
    reset           = 1'b1;
    rw_address_i    = '0;
    read_request_i  = 1'b0;
    write_request_i = 1'b0;
    write_data_i    = '0;
    write_strobe_i  = '0;
    gpio_input_i    = '0;
    error_count     = 0;
    check_count     = 0;
    lfsr_state      = 32'hb196;
    oe_copy         = '0;
    out_copy        = '0;
    in_copy         = '0;
    test_name       = "reset";
    repeat (5) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);

    check_value("read_response_o", '0, 32'(read_response_o));
    check_value("write_response_o", '0, 32'(write_response_o));
    check_value("gpio_oe_o", '0, 32'(gpio_oe_o));
    check_value("gpio_output_o", '0, 32'(gpio_output_o));
    check_value("timer_irq_o", '0, 32'(timer_irq_o));
    read_expect(timer_reg(soc_pkg::TIMER_CTRL_OFS), '0);
    read_expect(timer_reg(soc_pkg::TIMER_MTIME_LO_OFS), '0);
    read_expect(timer_reg(soc_pkg::TIMER_CMP_LO_OFS), 32'hFFFF_FFFF);
    read_expect(timer_reg(soc_pkg::TIMER_CMP_HI_OFS), 32'hFFFF_FFFF);

    // Full words first so no byte is left undefined
    test_name = "ram";
    for (int i = 0; i < RAM_TEST_WORDS; i++) begin
      ram_words[i] = (i == 0) ? '0 : soc_pkg::ram_index_t'(random_bits(10));
      write_word(ram_addr(ram_words[i]), random_bits(32), 4'hF);
    end
    for (int i = 0; i < 3 * RAM_TEST_WORDS; i++) begin
      write_word(ram_addr(ram_words[4'(random_bits(4))]), random_bits(32),
                 soc_pkg::bus_strobe_t'(random_bits(4)));
    end
    for (int i = 0; i < RAM_TEST_WORDS; i++) begin
      read_check(ram_addr(ram_words[i]));
    end

    test_name = "gpio";
    write_word(gpio_reg(soc_pkg::GPIO_OE_OFS), random_bits(32), '0);
    check_value("gpio_oe_o", 32'(oe_copy), 32'(gpio_oe_o));
    read_check(gpio_reg(soc_pkg::GPIO_OE_OFS));
    write_word(gpio_reg(soc_pkg::GPIO_OUT_OFS), random_bits(32), 4'hF);
    check_value("gpio_output_o", 32'(out_copy), 32'(gpio_output_o));
    write_word(gpio_reg(soc_pkg::GPIO_SET_OFS), random_bits(32), 4'hF);
    check_value("gpio_output_o after set", 32'(out_copy), 32'(gpio_output_o));
    write_word(gpio_reg(soc_pkg::GPIO_CLR_OFS), random_bits(32), 4'hF);
    check_value("gpio_output_o after clear", 32'(out_copy), 32'(gpio_output_o));
    read_check(gpio_reg(soc_pkg::GPIO_OUT_OFS));
    in_copy      = soc_pkg::gpio_t'(random_bits(8));
    gpio_input_i = in_copy;
    repeat (3) @(negedge clock);
    read_check(gpio_reg(soc_pkg::GPIO_IN_OFS));
    read_check(gpio_reg(5'h14));

    test_name = "timer";
    write_word(timer_reg(soc_pkg::TIMER_CTRL_OFS), 32'd1, 4'hF);
    read_value(timer_reg(soc_pkg::TIMER_MTIME_LO_OFS), prev);
    repeat (3) begin
      read_value(timer_reg(soc_pkg::TIMER_MTIME_LO_OFS), data);
      check_count++;
      assert (data > prev) else begin
        error_count++;
        $display("FAIL %s mtime increase: expected above %h actual %h", test_name, prev, data);
      end
      prev = data;
    end
    write_word(timer_reg(soc_pkg::TIMER_CMP_HI_OFS), '0, 4'hF);
    write_word(timer_reg(soc_pkg::TIMER_CMP_LO_OFS), 32'd64, 4'hF);
    wait_for_irq(1'b1, "a small compare value");
    write_word(timer_reg(soc_pkg::TIMER_CMP_HI_OFS), 32'hFFFF_FFFF, 4'hF);
    wait_for_irq(1'b0, "raising the compare value");
    write_word(timer_reg(soc_pkg::TIMER_CMP_HI_OFS), '0, 4'hF);
    wait_for_irq(1'b1, "lowering the compare value again");
    write_word(timer_reg(soc_pkg::TIMER_CTRL_OFS), '0, 4'hF);
    wait_for_irq(1'b0, "clearing the enable bit");

    // Just past RAM aliases word 0 in the low offset bits
    test_name = "unmapped";
    read_check(32'h4000_0000);
    read_check(soc_pkg::RAM_BASE + soc_pkg::RAM_SIZE);
    write_word(32'h4000_0000, random_bits(32), 4'hF);
    write_word(soc_pkg::RAM_BASE + soc_pkg::RAM_SIZE, random_bits(32), 4'hF);
    write_word(soc_pkg::GPIO_BASE + soc_pkg::GPIO_SIZE + 32'h4, random_bits(32), 4'hF);
    for (int i = 0; i < RAM_TEST_WORDS; i++) begin
      read_check(ram_addr(ram_words[i]));
    end
    read_check(gpio_reg(soc_pkg::GPIO_OE_OFS));
    read_check(gpio_reg(soc_pkg::GPIO_OUT_OFS));

    repeat (2) @(negedge clock);
    $display("Checks: %0d  Errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* source/soc_top.sv */
// Subsystem top level connecting the bus controller to the RAM, timer and GPIO devices
`timescale 1ns/1ps

module soc_top (
  input  logic                 clock,
  input  logic                 reset,
  // Manager port
  input  soc_pkg::bus_addr_t   rw_address_i,
  input  logic                 read_request_i,
  input  logic                 write_request_i,
  input  soc_pkg::bus_data_t   write_data_i,
  input  soc_pkg::bus_strobe_t write_strobe_i,
  output soc_pkg::bus_data_t   read_data_o,
  output logic                 read_response_o,
  output logic                 write_response_o,
  // Pins
  input  soc_pkg::gpio_t       gpio_input_i,
  output soc_pkg::gpio_t       gpio_oe_o,
  output soc_pkg::gpio_t       gpio_output_o,
  output logic                 timer_irq_o
);

  device_bus_if ram_bus ();
  device_bus_if timer_bus ();
  device_bus_if gpio_bus ();

  bus_controller u_bus_controller (
    .clock            (clock),
    .reset            (reset),
    .rw_address_i     (rw_address_i),
    .read_request_i   (read_request_i),
    .write_request_i  (write_request_i),
    .write_data_i     (write_data_i),
    .write_strobe_i   (write_strobe_i),
    .read_data_o      (read_data_o),
    .read_response_o  (read_response_o),
    .write_response_o (write_response_o),
    .ram_bus          (ram_bus.controller),
    .timer_bus        (timer_bus.controller),
    .gpio_bus         (gpio_bus.controller)
  );

  system_ram u_ram (
    .clock (clock),
    .reset (reset),
    .bus   (ram_bus.device)
  );

  machine_timer u_timer (
    .clock       (clock),
    .reset       (reset),
    .bus         (timer_bus.device),
    .timer_irq_o (timer_irq_o)
  );

  gpio_port u_gpio (
    .clock         (clock),
    .reset         (reset),
    .bus           (gpio_bus.device),
    .gpio_input_i  (gpio_input_i),
    .gpio_oe_o     (gpio_oe_o),
    .gpio_output_o (gpio_output_o)
  );

endmodule

/* source/machine_timer.sv */
// Free-running 64-bit machine timer device with compare register and interrupt level
`timescale 1ns/1ps

module machine_timer (
  input  logic         clock,
  input  logic         reset,
  device_bus_if.device bus,
  output logic         timer_irq_o
);

  logic               enable_q;
  logic [63:0]        mtime_q;
  logic [63:0]        mtime_d;
  logic [63:0]        mtimecmp_q;
  soc_pkg::bus_data_t read_data_q;
  logic               read_response_q;
  logic               write_response_q;

  // Count, then let a bus write override the written half
  always_comb begin
    mtime_d = enable_q ? mtime_q + 64'd1 : mtime_q;
    if (bus.write_request) begin
      if (bus.reg_offset == soc_pkg::TIMER_MTIME_LO_OFS) begin
        mtime_d[31:0] = bus.write_data;
      end
      if (bus.reg_offset == soc_pkg::TIMER_MTIME_HI_OFS) begin
        mtime_d[63:32] = bus.write_data;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Control state
  // --------------------------------------------------------------------------

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      enable_q         <= 1'b0;
      mtime_q          <= '0;
      mtimecmp_q       <= '1;
      timer_irq_o      <= 1'b0;
      read_response_q  <= 1'b0;
      write_response_q <= 1'b0;
    end else begin
      mtime_q          <= mtime_d;
      read_response_q  <= bus.read_request;
      write_response_q <= bus.write_request;
      // Level interrupt while enabled and compare reached
      timer_irq_o      <= enable_q && (mtime_q >= mtimecmp_q);
      if (bus.write_request) begin
        case (bus.reg_offset)
          soc_pkg::TIMER_CTRL_OFS:   enable_q          <= bus.write_data[0];
          soc_pkg::TIMER_CMP_LO_OFS: mtimecmp_q[31:0]  <= bus.write_data;
          soc_pkg::TIMER_CMP_HI_OFS: mtimecmp_q[63:32] <= bus.write_data;
          default: ;
        endcase
      end
    end
  end

  // --------------------------------------------------------------------------
  // Register reads
  // --------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (bus.read_request) begin
      case (bus.reg_offset)
        soc_pkg::TIMER_CTRL_OFS:     read_data_q <= {31'b0, enable_q};
        soc_pkg::TIMER_MTIME_LO_OFS: read_data_q <= mtime_q[31:0];
        soc_pkg::TIMER_MTIME_HI_OFS: read_data_q <= mtime_q[63:32];
        soc_pkg::TIMER_CMP_LO_OFS:   read_data_q <= mtimecmp_q[31:0];
        soc_pkg::TIMER_CMP_HI_OFS:   read_data_q <= mtimecmp_q[63:32];
        default:                     read_data_q <= '0;
      endcase
    end
  end

  assign bus.read_data      = read_data_q;
  assign bus.read_response  = read_response_q;
  assign bus.write_response = write_response_q;

endmodule

/* source/gpio_port.sv */
// GPIO device with synchronized inputs, output enables and set or clear of output bits
`timescale 1ns/1ps

module gpio_port (
  input  logic           clock,
  input  logic           reset,
  device_bus_if.device   bus,
  input  soc_pkg::gpio_t gpio_input_i,
  output soc_pkg::gpio_t gpio_oe_o,
  output soc_pkg::gpio_t gpio_output_o
);

  soc_pkg::gpio_t     sync_meta_q;
  soc_pkg::gpio_t     sync_q;
  soc_pkg::gpio_t     oe_q;
  soc_pkg::gpio_t     out_q;
  soc_pkg::gpio_t     wr_bits;
  soc_pkg::bus_data_t read_data_q;
  logic               read_response_q;
  logic               write_response_q;

  assign wr_bits = bus.write_data[soc_pkg::GPIO_WIDTH-1:0];

  // Two-flop input synchronizer
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sync_meta_q <= '0;
      sync_q      <= '0;
    end else begin
      sync_meta_q <= gpio_input_i;
      sync_q      <= sync_meta_q;
    end
  end

  // --------------------------------------------------------------------------
  // Register writes and responses
  // --------------------------------------------------------------------------

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      oe_q             <= '0;
      out_q            <= '0;
      read_response_q  <= 1'b0;
      write_response_q <= 1'b0;
    end else begin
      read_response_q  <= bus.read_request;
      write_response_q <= bus.write_request;
      if (bus.write_request) begin
        case (bus.reg_offset)
          soc_pkg::GPIO_OE_OFS:  oe_q  <= wr_bits;
          soc_pkg::GPIO_OUT_OFS: out_q <= wr_bits;
          soc_pkg::GPIO_SET_OFS: out_q <= out_q | wr_bits;
          soc_pkg::GPIO_CLR_OFS: out_q <= out_q & ~wr_bits;
          default: ;
        endcase
      end
    end
  end

  // Reads zero-extend the pin vectors
  always_ff @(posedge clock) begin
    if (bus.read_request) begin
      case (bus.reg_offset)
        soc_pkg::GPIO_IN_OFS:  read_data_q <= soc_pkg::bus_data_t'(sync_q);
        soc_pkg::GPIO_OE_OFS:  read_data_q <= soc_pkg::bus_data_t'(oe_q);
        soc_pkg::GPIO_OUT_OFS: read_data_q <= soc_pkg::bus_data_t'(out_q);
        default:               read_data_q <= '0;
      endcase
    end
  end

  assign bus.read_data      = read_data_q;
  assign bus.read_response  = read_response_q;
  assign bus.write_response = write_response_q;
  assign gpio_oe_o          = oe_q;
  assign gpio_output_o      = out_q;

endmodule

/* source/system_ram.sv */
// Word-organized RAM device on the system bus, with byte write strobes
`timescale 1ns/1ps

module system_ram (
  input logic          clock,
  input logic          reset,
  device_bus_if.device bus
);

  soc_pkg::bus_data_t mem [soc_pkg::RAM_WORDS];
  soc_pkg::ram_index_t word_index;
  soc_pkg::bus_data_t  read_data_q;
  logic                read_response_q;
  logic                write_response_q;

  // Byte offset to word index
  assign word_index = bus.offset[$bits(soc_pkg::ram_index_t)+1:2];

  // Only strobed bytes change
  always_ff @(posedge clock) begin
    if (bus.write_request) begin
      for (int b = 0; b < $bits(soc_pkg::bus_strobe_t); b++) begin
        if (bus.write_strobe[b]) begin
          mem[word_index][8*b +: 8] <= bus.write_data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (bus.read_request) begin
      read_data_q <= mem[word_index];
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      read_response_q  <= 1'b0;
      write_response_q <= 1'b0;
    end else begin
      read_response_q  <= bus.read_request;
      write_response_q <= bus.write_request;
    end
  end

  assign bus.read_data      = read_data_q;
  assign bus.read_response  = read_response_q;
  assign bus.write_response = write_response_q;

endmodule

/* source/bus_controller.sv */
// Decodes each manager access, issues it to one device and returns the response two cycles later
`timescale 1ns/1ps

module bus_controller (
  input  logic                 clock,
  input  logic                 reset,
  input  soc_pkg::bus_addr_t   rw_address_i,
  input  logic                 read_request_i,
  input  logic                 write_request_i,
  input  soc_pkg::bus_data_t   write_data_i,
  input  soc_pkg::bus_strobe_t write_strobe_i,
  output soc_pkg::bus_data_t   read_data_o,
  output logic                 read_response_o,
  output logic                 write_response_o,
  device_bus_if.controller     ram_bus,
  device_bus_if.controller     timer_bus,
  device_bus_if.controller     gpio_bus
);

  function automatic logic in_region(soc_pkg::bus_addr_t addr, soc_pkg::bus_addr_t base,
                                     soc_pkg::bus_addr_t size);
    return (addr >= base) && ((addr - base) < size);
  endfunction

  soc_pkg::bus_state_e  state_q;
  logic                 wait_q;
  logic                 write_q;
  logic                 sel_ram_q;
  logic                 sel_timer_q;
  logic                 sel_gpio_q;
  logic                 unmapped_q;
  soc_pkg::bus_addr_t   offset_q;
  soc_pkg::bus_data_t   wdata_q;
  soc_pkg::bus_strobe_t strobe_q;

  logic                 hit_ram;
  logic                 hit_timer;
  logic                 hit_gpio;
  soc_pkg::bus_addr_t   region_offset;
  logic                 accept;
  logic                 issue_now;
  logic                 dev_read_response;
  logic                 dev_write_response;
  soc_pkg::bus_data_t   dev_read_data;

  // --------------------------------------------------------------------------
  // Region decode
  // --------------------------------------------------------------------------

  always_comb begin
    hit_ram   = in_region(rw_address_i, soc_pkg::RAM_BASE, soc_pkg::RAM_SIZE);
    hit_timer = in_region(rw_address_i, soc_pkg::TIMER_BASE, soc_pkg::TIMER_SIZE);
    hit_gpio  = in_region(rw_address_i, soc_pkg::GPIO_BASE, soc_pkg::GPIO_SIZE);
    if (hit_timer) begin
      region_offset = rw_address_i - soc_pkg::TIMER_BASE;
    end else if (hit_gpio) begin
      region_offset = rw_address_i - soc_pkg::GPIO_BASE;
    end else begin
      region_offset = rw_address_i - soc_pkg::RAM_BASE;
    end
  end

  // New accesses are taken in IDLE only
  assign accept = (state_q == soc_pkg::IDLE) && (read_request_i || write_request_i);

  // Device request pulses in the first ISSUE cycle only
  assign issue_now = (state_q == soc_pkg::ISSUE) && wait_q;

  // --------------------------------------------------------------------------
  // FSM and manager response
  // --------------------------------------------------------------------------

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q          <= soc_pkg::IDLE;
      wait_q           <= 1'b0;
      write_q          <= 1'b0;
      sel_ram_q        <= 1'b0;
      sel_timer_q      <= 1'b0;
      sel_gpio_q       <= 1'b0;
      unmapped_q       <= 1'b0;
      read_response_o  <= 1'b0;
      write_response_o <= 1'b0;
      read_data_o      <= '0;
    end else begin
      read_response_o  <= 1'b0;
      write_response_o <= 1'b0;
      read_data_o      <= '0;
      case (state_q)
        soc_pkg::ISSUE: begin
          if (wait_q) begin
            wait_q <= 1'b0;
          end else begin
            state_q          <= soc_pkg::COMPLETE;
            // Unmapped accesses complete on their own with zero data
            read_response_o  <= dev_read_response || (unmapped_q && !write_q);
            write_response_o <= dev_write_response || (unmapped_q && write_q);
            read_data_o      <= dev_read_response ? dev_read_data : '0;
          end
        end
        default: begin
          if (accept) begin
            state_q     <= soc_pkg::ISSUE;
            wait_q      <= 1'b1;
            write_q     <= write_request_i;
            sel_ram_q   <= hit_ram;
            sel_timer_q <= hit_timer;
            sel_gpio_q  <= hit_gpio;
            unmapped_q  <= !(hit_ram || hit_timer || hit_gpio);
          end else begin
            state_q <= soc_pkg::IDLE;
          end
        end
      endcase
    end
  end

  // Access payload
  always_ff @(posedge clock) begin
    if (accept) begin
      offset_q <= region_offset;
      wdata_q  <= write_data_i;
      strobe_q <= write_strobe_i;
    end
  end

  // --------------------------------------------------------------------------
  // Device ports
  // --------------------------------------------------------------------------

  always_comb begin
    dev_read_response  = 1'b0;
    dev_write_response = 1'b0;
    dev_read_data      = '0;
    if (sel_ram_q) begin
      dev_read_response  = ram_bus.read_response;
      dev_write_response = ram_bus.write_response;
      dev_read_data      = ram_bus.read_data;
    end else if (sel_timer_q) begin
      dev_read_response  = timer_bus.read_response;
      dev_write_response = timer_bus.write_response;
      dev_read_data      = timer_bus.read_data;
    end else if (sel_gpio_q) begin
      dev_read_response  = gpio_bus.read_response;
      dev_write_response = gpio_bus.write_response;
      dev_read_data      = gpio_bus.read_data;
    end
  end

  assign ram_bus.read_request    = issue_now && sel_ram_q && !write_q;
  assign ram_bus.write_request   = issue_now && sel_ram_q && write_q;
  assign ram_bus.offset          = offset_q;
  assign ram_bus.write_data      = wdata_q;
  assign ram_bus.write_strobe    = strobe_q;

  assign timer_bus.read_request  = issue_now && sel_timer_q && !write_q;
  assign timer_bus.write_request = issue_now && sel_timer_q && write_q;
  assign timer_bus.offset        = offset_q;
  assign timer_bus.write_data    = wdata_q;
  assign timer_bus.write_strobe  = strobe_q;

  assign gpio_bus.read_request   = issue_now && sel_gpio_q && !write_q;
  assign gpio_bus.write_request  = issue_now && sel_gpio_q && write_q;
  assign gpio_bus.offset         = offset_q;
  assign gpio_bus.write_data     = wdata_q;
  assign gpio_bus.write_strobe   = strobe_q;

endmodule

/* source/device_bus_if.sv */
// One device port of the system bus, connecting the bus controller to a single device
`timescale 1ns/1ps

interface device_bus_if;

  logic                 read_request;
  logic                 write_request;
  soc_pkg::bus_addr_t   offset;
  soc_pkg::reg_offset_t reg_offset;
  soc_pkg::bus_data_t   write_data;
  soc_pkg::bus_strobe_t write_strobe;
  soc_pkg::bus_data_t   read_data;
  logic                 read_response;
  logic                 write_response;

  // Register devices only decode the low offset bits
  assign reg_offset = offset[$bits(soc_pkg::reg_offset_t)-1:0];

  modport controller (
    output read_request, write_request, offset, write_data, write_strobe,
    input  read_data, read_response, write_response
  );

  modport device (
    input  read_request, write_request, offset, reg_offset, write_data, write_strobe,
    output read_data, read_response, write_response
  );

endinterface

/* source/soc_pkg.sv */
// Address map, data widths, register offsets and bus states shared by all subsystem RTL
package soc_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------

  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_strobe_t;
  typedef logic [9:0]  ram_index_t;
  typedef logic [4:0]  reg_offset_t;

  localparam int GPIO_WIDTH = 8;

  typedef logic [GPIO_WIDTH-1:0] gpio_t;

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------

  localparam bus_addr_t RAM_BASE   = 32'h0000_0000;
  localparam bus_addr_t RAM_SIZE   = 32'd4096;
  localparam bus_addr_t TIMER_BASE = 32'h8001_0000;
  localparam bus_addr_t TIMER_SIZE = 32'd32;
  localparam bus_addr_t GPIO_BASE  = 32'h8002_0000;
  localparam bus_addr_t GPIO_SIZE  = 32'd32;

  // One RAM word per four bytes of region
  localparam int RAM_WORDS = RAM_SIZE / 4;

  // Timer registers
  localparam reg_offset_t TIMER_CTRL_OFS     = 5'h00;
  localparam reg_offset_t TIMER_MTIME_LO_OFS = 5'h04;
  localparam reg_offset_t TIMER_MTIME_HI_OFS = 5'h08;
  localparam reg_offset_t TIMER_CMP_LO_OFS   = 5'h0C;
  localparam reg_offset_t TIMER_CMP_HI_OFS   = 5'h10;

  // GPIO registers
  localparam reg_offset_t GPIO_IN_OFS  = 5'h00;
  localparam reg_offset_t GPIO_OE_OFS  = 5'h04;
  localparam reg_offset_t GPIO_OUT_OFS = 5'h08;
  localparam reg_offset_t GPIO_SET_OFS = 5'h0C;
  localparam reg_offset_t GPIO_CLR_OFS = 5'h10;

  // Bus controller FSM
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    COMPLETE
  } bus_state_e;

endpackage
